// ==== verilog/bp_pkg.sv ====
`default_nettype none

// shared geometry and encodings for the fetch-side predictor
package bp_pkg;

    // datapath widths
    localparam int addr_w = 32;
    localparam int inst_w = 32;
    localparam int opc_w  = 7;

    // local history per entry
    localparam int hist_len = 2;

    // pc slice that selects a history slot, pc[9:2]
    localparam int idx_lo = 2;
    localparam int idx_w  = 8;

    // table sizes
    localparam int hist_entries = 1 << idx_w;
    localparam int ctr_idx_w    = idx_w + hist_len;
    localparam int ctr_entries  = 1 << ctr_idx_w;

    // sequential step and fetch address out of reset
    localparam logic [addr_w-1:0] pc_step  = 4;
    localparam logic [addr_w-1:0] reset_pc = '0;

    // RISC-V major opcodes seen by the front end
    typedef enum logic [opc_w-1:0] {
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    // two-bit saturating counter, msb is the prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_state_e;

    // counters start one step on the taken side
    localparam ctr_state_e ctr_reset = weak_taken;

endpackage

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [bp_pkg::addr_w-1:0] query_pc,
    input  wire  [bp_pkg::addr_w-1:0] query_inst,
    input  wire                       upd_valid,
    input  wire  [bp_pkg::addr_w-1:0] upd_pc,
    input  wire                       upd_taken,
    output logic                      pred_taken,
    output logic [bp_pkg::addr_w-1:0] pred_imm
);

    import bp_pkg::*;

    // per-pc local history and the counters it selects
    logic [hist_len-1:0] hist_tbl [hist_entries];
    ctr_state_e          ctr_tbl  [ctr_entries];

    // query side
    logic [idx_w-1:0]     q_slot;
    logic [hist_len-1:0]  q_hist;
    logic [ctr_idx_w-1:0] q_ctr_idx;
    ctr_state_e           q_ctr;
    opcode_e              q_opc;
    logic [addr_w-1:0]    j_imm;
    logic [addr_w-1:0]    b_imm;

    // update side
    logic [idx_w-1:0]     u_slot;
    logic [hist_len-1:0]  u_hist;
    logic [ctr_idx_w-1:0] u_ctr_idx;
    ctr_state_e           u_ctr;
    ctr_state_e           u_ctr_next;

    assign q_slot    = query_pc[idx_lo +: idx_w];
    assign q_hist    = hist_tbl[q_slot];
    assign q_ctr_idx = {q_slot, q_hist};
    assign q_ctr     = ctr_tbl[q_ctr_idx];
    assign q_opc     = opcode_e'(query_inst[opc_w-1:0]);

    // J-type and B-type immediates, both sign extended with bit 0 clear
    assign j_imm = {{12{query_inst[31]}}, query_inst[19:12], query_inst[20],
                    query_inst[30:21], 1'b0};
    assign b_imm = {{20{query_inst[31]}}, query_inst[7], query_inst[30:25],
                    query_inst[11:8], 1'b0};

    always_comb begin
        pred_imm = b_imm;
        case (q_opc)
            opc_jal: begin
                pred_taken = 1'b1;
                pred_imm   = j_imm;
            end
            opc_branch: begin
                pred_taken = q_ctr[1];
            end
            // no indirect target prediction
            opc_jalr: begin
                pred_taken = 1'b0;
            end
            default: begin
                pred_taken = 1'b0;
            end
        endcase
    end

    assign u_slot    = upd_pc[idx_lo +: idx_w];
    assign u_hist    = hist_tbl[u_slot];
    assign u_ctr_idx = {u_slot, u_hist};
    assign u_ctr     = ctr_tbl[u_ctr_idx];

    // saturating step towards the committed outcome
    always_comb begin
        case (u_ctr)
            strong_not_taken: u_ctr_next = upd_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   u_ctr_next = upd_taken ? weak_taken : strong_not_taken;
            weak_taken:       u_ctr_next = upd_taken ? strong_taken : weak_not_taken;
            default:          u_ctr_next = upd_taken ? strong_taken : weak_taken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < hist_entries; i++) begin
                hist_tbl[i] <= '0;
            end
            for (int i = 0; i < ctr_entries; i++) begin
                ctr_tbl[i] <= ctr_reset;
            end
        end else if (upd_valid) begin
            ctr_tbl[u_ctr_idx] <= u_ctr_next;
            // newest outcome enters at the lsb
            hist_tbl[u_slot] <= {u_hist[hist_len-2:0], upd_taken};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       inst_valid,
    input  wire                       pred_taken,
    input  wire  [bp_pkg::addr_w-1:0] pred_imm,
    input  wire                       redirect_valid,
    input  wire  [bp_pkg::addr_w-1:0] redirect_pc,
    output logic [bp_pkg::addr_w-1:0] fetch_pc,
    output logic [bp_pkg::addr_w-1:0] pred_target
);

    import bp_pkg::*;

    logic [addr_w-1:0] seq_pc;
    logic [addr_w-1:0] next_pc;

    // pc-relative target of the instruction being fetched
    assign pred_target = fetch_pc + pred_imm;

    // fall-through address
    assign seq_pc = fetch_pc + pc_step;

    // commit-side redirect overrides anything fetch decides this cycle
    always_comb begin
        if (redirect_valid) begin
            next_pc = redirect_pc;
        end else if (inst_valid && pred_taken) begin
            next_pc = pred_target;
        end else if (inst_valid) begin
            next_pc = seq_pc;
        end else begin
            // no instruction this cycle, hold the pc
            next_pc = fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= reset_pc;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       commit_valid,
    input  wire  [bp_pkg::addr_w-1:0] commit_pc,
    input  wire                       commit_is_branch,
    input  wire                       commit_taken,
    input  wire                       commit_pred_taken,
    input  wire  [bp_pkg::addr_w-1:0] commit_target,
    output logic                      upd_valid,
    output logic [bp_pkg::addr_w-1:0] upd_pc,
    output logic                      upd_taken,
    output logic                      redirect_valid,
    output logic [bp_pkg::addr_w-1:0] redirect_pc
);

    import bp_pkg::*;

    logic              mispredict;
    logic [addr_w-1:0] fix_pc;

    // jal is always predicted taken, so only jalr and branches can miss here
    assign mispredict = commit_valid && (commit_taken != commit_pred_taken);

    // where fetch should have gone
    assign fix_pc = commit_taken ? commit_target : commit_pc + pc_step;

    // strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            upd_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            // only conditional branches train the counters
            upd_valid      <= commit_valid && commit_is_branch;
            redirect_valid <= mispredict;
        end
    end

    // payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        upd_pc      <= commit_pc;
        upd_taken   <= commit_taken;
        redirect_pc <= fix_pc;
    end

endmodule

`default_nettype wire

// ==== verilog/frontend_predict_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_predict_top (
    input  wire                       clk,
    input  wire                       rst,

    // fetch side
    input  wire                       inst_valid,
    input  wire  [bp_pkg::inst_w-1:0] inst,

    // commit side from the reorder buffer
    input  wire                       commit_valid,
    input  wire  [bp_pkg::addr_w-1:0] commit_pc,
    input  wire                       commit_is_branch,
    input  wire                       commit_taken,
    input  wire                       commit_pred_taken,
    input  wire  [bp_pkg::addr_w-1:0] commit_target,

    output wire  [bp_pkg::addr_w-1:0] fetch_pc,
    output wire                       pred_taken,
    output wire  [bp_pkg::addr_w-1:0] pred_imm,
    output wire  [bp_pkg::addr_w-1:0] pred_target,
    output wire                       redirect_valid
);

    import bp_pkg::*;

    // resolver to predictor
    wire              upd_valid;
    wire [addr_w-1:0] upd_pc;
    wire              upd_taken;

    // resolver to fetch
    wire [addr_w-1:0] redirect_pc;

    fetch_pc_unit i_fetch_pc_unit (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .pred_taken     (pred_taken),
        .pred_imm       (pred_imm),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (fetch_pc),
        .pred_target    (pred_target)
    );

    branch_predictor i_branch_predictor (
        .clk        (clk),
        .rst        (rst),
        .query_pc   (fetch_pc),
        .query_inst (inst),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .pred_taken (pred_taken),
        .pred_imm   (pred_imm)
    );

    branch_resolver i_branch_resolver (
        .clk               (clk),
        .rst               (rst),
        .commit_valid      (commit_valid),
        .commit_pc         (commit_pc),
        .commit_is_branch  (commit_is_branch),
        .commit_taken      (commit_taken),
        .commit_pred_taken (commit_pred_taken),
        .commit_target     (commit_target),
        .upd_valid         (upd_valid),
        .upd_pc            (upd_pc),
        .upd_taken         (upd_taken),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_predict_model.svh ====
`ifndef tb_predict_model_svh
`define tb_predict_model_svh

// mirror of the local history table and the counter table
logic [hist_len-1:0] model_hist [hist_entries];
logic [1:0]          model_ctr  [ctr_entries];

task automatic clear_tables();
    for (int i = 0; i < hist_entries; i++) begin
        model_hist[i] = '0;
    end
    // counters leave reset one step on the taken side
    for (int i = 0; i < ctr_entries; i++) begin
        model_ctr[i] = weak_taken;
    end
endtask

// counter slot for a pc, pc slice joined with that slot's history
function automatic logic [ctr_idx_w-1:0] ctr_index(input logic [31:0] pc);
    logic [idx_w-1:0] slot;
    slot = pc[idx_lo +: idx_w];
    return {slot, model_hist[slot]};
endfunction

// jal taken, branch by counter msb, anything else not taken
function automatic logic predict_taken(input logic [31:0] pc, input logic [31:0] word);
    logic [1:0] ctr;
    ctr = model_ctr[ctr_index(pc)];
    if (word[6:0] == opc_jal) begin
        return 1'b1;
    end else if (word[6:0] == opc_branch) begin
        return ctr[1];
    end
    return 1'b0;
endfunction

// J immediate for jal, B immediate for every other word
function automatic logic [31:0] predict_imm(input logic [31:0] word);
    logic [31:0] imm;
    imm = '0;
    if (word[6:0] == opc_jal) begin
        imm[20]    = word[31];
        imm[19:12] = word[19:12];
        imm[11]    = word[20];
        imm[10:1]  = word[30:21];
        if (word[31]) begin
            imm[31:21] = '1;
        end
    end else begin
        imm[12]   = word[31];
        imm[11]   = word[7];
        imm[10:5] = word[30:25];
        imm[4:1]  = word[11:8];
        if (word[31]) begin
            imm[31:13] = '1;
        end
    end
    return imm;
endfunction

// redirect first, then a taken prediction, then pc + 4, else hold
function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc, input logic valid,
                                              input logic taken, input logic [31:0] target,
                                              input logic redir, input logic [31:0] redir_pc);
    if (redir) begin
        return redir_pc;
    end else if (valid && taken) begin
        return target;
    end else if (valid) begin
        return pc + 32'd4;
    end
    return pc;
endfunction

// saturating step of the selected counter, then shift the outcome in
task automatic train_tables(input logic [31:0] pc, input logic taken);
    logic [idx_w-1:0]     slot;
    logic [ctr_idx_w-1:0] idx;
    logic [1:0]           ctr;
    logic [hist_len-1:0]  hist;
    slot = pc[idx_lo +: idx_w];
    idx  = ctr_index(pc);
    ctr  = model_ctr[idx];
    if (taken && ctr != 2'b11) begin
        ctr = ctr + 2'd1;
    end else if (!taken && ctr != 2'b00) begin
        ctr = ctr - 2'd1;
    end
    model_ctr[idx] = ctr;
    hist = model_hist[slot] << 1;
    hist[0] = taken;
    model_hist[slot] = hist;
endtask

// 32-bit xorshift, 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

// ==== testbench/tb_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_top;

    import bp_pkg::*;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_is_branch;
    logic        commit_taken;
    logic        commit_pred_taken;
    logic [31:0] commit_target;
    wire  [31:0] fetch_pc;
    wire         pred_taken;
    wire  [31:0] pred_imm;
    wire  [31:0] pred_target;
    wire         redirect_valid;

    // model state of the resolver stage and the pc
    logic [31:0] exp_pc;
    logic        exp_upd_valid;
    logic [31:0] exp_upd_pc;
    logic        exp_upd_taken;
    logic        exp_redir_valid;
    logic [31:0] exp_redir_pc;
    logic        exp_taken;
    logic [31:0] exp_imm;
    logic [31:0] rng;
    int          compare_errors = 0;
    int          directed_errors = 0;
    int          cycles_checked = 0;

    `include "tb_predict_model.svh"

    frontend_predict_top i_dut (
        .clk               (clk),
        .rst               (rst),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .commit_valid      (commit_valid),
        .commit_pc         (commit_pc),
        .commit_is_branch  (commit_is_branch),
        .commit_taken      (commit_taken),
        .commit_pred_taken (commit_pred_taken),
        .commit_target     (commit_target),
        .fetch_pc          (fetch_pc),
        .pred_taken        (pred_taken),
        .pred_imm          (pred_imm),
        .pred_target       (pred_target),
        .redirect_valid    (redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] make_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] make_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    function automatic logic [31:0] make_jalr();
        return {12'h000, 5'd1, 3'b000, 5'd0, 7'b1100111};
    endfunction

    // addi x0, x0, 0
    function automatic logic [31:0] make_nop();
        return 32'h0000_0013;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // one fetch cycle, commit strobe cleared unless posted again
    task automatic drive(input logic valid, input logic [31:0] word);
        @(posedge clk);
        #2;
        inst_valid   = valid;
        inst         = word;
        commit_valid = 1'b0;
    endtask

    task automatic post_commit(input logic [31:0] pc, input logic is_branch, input logic taken,
                               input logic pred, input logic [31:0] target);
        commit_valid      = 1'b1;
        commit_pc         = pc;
        commit_is_branch  = is_branch;
        commit_taken      = taken;
        commit_pred_taken = pred;
        commit_target     = target;
    endtask

    task automatic wait_redirect(input int max_cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < max_cycles) begin
            @(negedge clk);
            seen = (redirect_valid === 1'b1);
            n++;
        end
        if (!seen) begin
            $display("timeout: redirect_valid did not rise within %0d cycles", max_cycles);
            directed_errors++;
        end
    endtask

    task automatic expect_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            show_mismatch(name, got, exp);
            directed_errors++;
        end
    endtask

    // compare at the falling edge, then step the model across the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            clear_tables();
            exp_pc          = reset_pc;
            exp_upd_valid   = 1'b0;
            exp_redir_valid = 1'b0;
        end else begin
            exp_taken = predict_taken(exp_pc, inst);
            exp_imm   = predict_imm(inst);
            if (fetch_pc !== exp_pc) begin
                show_mismatch("fetch_pc", fetch_pc, exp_pc);
                compare_errors++;
            end
            if (pred_taken !== exp_taken) begin
                show_mismatch("pred_taken", 32'(pred_taken), 32'(exp_taken));
                compare_errors++;
            end
            if (pred_imm !== exp_imm) begin
                show_mismatch("pred_imm", pred_imm, exp_imm);
                compare_errors++;
            end
            if (pred_target !== exp_pc + exp_imm) begin
                show_mismatch("pred_target", pred_target, exp_pc + exp_imm);
                compare_errors++;
            end
            if (redirect_valid !== exp_redir_valid) begin
                show_mismatch("redirect_valid", 32'(redirect_valid), 32'(exp_redir_valid));
                compare_errors++;
            end
            cycles_checked++;
            exp_pc = next_fetch_pc(exp_pc, inst_valid, exp_taken, exp_pc + exp_imm,
                                   exp_redir_valid, exp_redir_pc);
            // training lands after this cycle's query
            if (exp_upd_valid) begin
                train_tables(exp_upd_pc, exp_upd_taken);
            end
            exp_upd_valid   = commit_valid && commit_is_branch;
            exp_upd_pc      = commit_pc;
            exp_upd_taken   = commit_taken;
            exp_redir_valid = commit_valid && (commit_taken != commit_pred_taken);
            exp_redir_pc    = commit_taken ? commit_target : commit_pc + 32'd4;
        end
    end

    initial begin
        logic [31:0] br;
        logic [31:0] word;
        int          k;
        rng               = 32'd9;
        rst               = 1'b1;
        inst_valid        = 1'b0;
        inst              = make_nop();
        commit_valid      = 1'b0;
        commit_pc         = '0;
        commit_is_branch  = 1'b0;
        commit_taken      = 1'b0;
        commit_pred_taken = 1'b0;
        commit_target     = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // first branch out of reset, fresh counters say taken
        inst_valid = 1'b1;
        inst       = make_branch(13'd16);
        #10;
        expect_word("fetch_pc", fetch_pc, reset_pc);
        expect_word("pred_taken", 32'(pred_taken), 32'd1);
        expect_word("pred_target", pred_target, reset_pc + 32'd16);

        // jal, jalr, plain instruction, backward jal
        drive(1'b1, make_jal(21'h100));
        #10;
        expect_word("pred_taken", 32'(pred_taken), 32'd1);
        expect_word("pred_target", pred_target, 32'h110);
        drive(1'b1, make_jalr());
        #10;
        expect_word("pred_taken", 32'(pred_taken), 32'd0);
        drive(1'b1, make_nop());
        drive(1'b1, make_jal(21'h1ffff8));
        #10;
        expect_word("fetch_pc", fetch_pc, 32'h118);

        // park fetch at 0x110 with a branch on the bus
        br = make_branch(13'd64);
        drive(1'b0, br);
        #10;
        expect_word("fetch_pc", fetch_pc, 32'h110);

        // not-taken commits saturate the history-00 counter
        for (k = 0; k < 6; k++) begin
            drive(1'b0, br);
            post_commit(32'h110, 1'b1, 1'b0, 1'b0, 32'h150);
        end
        drive(1'b0, br);
        drive(1'b0, br);
        #10;
        expect_word("pred_taken", 32'(pred_taken), 32'd0);

        // alternating outcomes, each history gets its own counter
        for (k = 0; k < 12; k++) begin
            drive(1'b0, br);
            post_commit(32'h110, 1'b1, k[0] == 1'b0, k[0] == 1'b0, 32'h150);
        end
        drive(1'b0, br);
        drive(1'b0, br);
        #10;
        expect_word("pred_taken", 32'(pred_taken), 32'd1);
        drive(1'b0, br);
        post_commit(32'h110, 1'b1, 1'b1, 1'b1, 32'h150);
        drive(1'b0, br);
        drive(1'b0, br);
        #10;
        expect_word("pred_taken", 32'(pred_taken), 32'd0);

        // taken branch predicted not taken, redirect beats a taken jal
        drive(1'b1, make_jal(21'h40));
        post_commit(32'h40, 1'b1, 1'b1, 1'b0, 32'h300);
        drive(1'b1, make_jal(21'h40));
        wait_redirect(8);
        drive(1'b1, make_nop());
        #10;
        expect_word("fetch_pc", fetch_pc, 32'h300);

        // not-taken branch predicted taken falls through to pc + 4
        drive(1'b1, make_nop());
        post_commit(32'h80, 1'b1, 1'b0, 1'b1, 32'h999c);
        drive(1'b1, make_nop());
        wait_redirect(8);
        drive(1'b1, make_nop());
        #10;
        expect_word("fetch_pc", fetch_pc, 32'h84);

        // jalr miss redirects without training
        drive(1'b1, make_nop());
        post_commit(32'hc0, 1'b0, 1'b1, 1'b0, 32'h500);
        drive(1'b1, make_nop());
        wait_redirect(8);
        drive(1'b0, make_nop());
        #10;
        expect_word("fetch_pc", fetch_pc, 32'h500);

        // stalled fetch holds even with a jal on the bus
        repeat (4) drive(1'b0, make_jal(21'h80));
        #10;
        expect_word("fetch_pc", fetch_pc, 32'h500);

        // random mix of fetches and commits
        for (k = 0; k < 400; k++) begin
            rng = xorshift32(rng);
            case (rng[3:2])
                2'd0:    word = make_branch({rng[16:5], 1'b0});
                2'd1:    word = make_jal({rng[24:5], 1'b0});
                2'd2:    word = make_jalr();
                default: word = make_nop();
            endcase
            drive(rng[0] | rng[1], word);
            rng = xorshift32(rng);
            if (rng[0]) begin
                post_commit({24'd0, rng[6:1], 2'b00}, rng[7] | rng[8], rng[9], rng[10],
                            {rng[31:2], 2'b00});
            end
        end

        repeat (3) drive(1'b0, make_nop());
        @(negedge clk);
        #1;
        $display("cycles checked %0d, compare errors %0d, directed errors %0d",
                 cycles_checked, compare_errors, directed_errors);
        if (compare_errors == 0 && directed_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+testbench
verilog/bp_pkg.sv
verilog/branch_predictor.sv
verilog/fetch_pc_unit.sv
verilog/branch_resolver.sv
verilog/frontend_predict_top.sv
testbench/tb_frontend_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the front-end predictor testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir"

verilator --binary --timing -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_frontend_top \
    -Mdir "$build_dir" \
    -f flist.f

"./$build_dir/Vtb_frontend_top" | tee "$log_file"

if grep -q "TEST FAILED" "$log_file"; then
    echo "simulation reported failure, see $log_file"
    exit 1
fi

echo "simulation finished without failure"
exit 0
